//--- hdl/mul16_pkg.sv
package mul16_pkg;

  // Operand byte, the input width of each quadrant multiplier
  localparam int HALF_W = 8;

  localparam int OPERAND_W = 2 * HALF_W;

  // Full product, also the width of the accumulation adders
  localparam int PRODUCT_W = 2 * OPERAND_W;

  // One operand word, seen whole or as its two bytes
  typedef union packed {
    logic [OPERAND_W-1:0] word;
    struct packed {
      logic [HALF_W-1:0] hi;
      logic [HALF_W-1:0] lo;
    } halves;
  } operand_u;

endpackage

//--- hdl/array_mult8.sv
`timescale 1ns/100ps

module array_mult8 (
  input  logic [mul16_pkg::HALF_W-1:0]    x,
  input  logic [mul16_pkg::HALF_W-1:0]    y,
  output logic [mul16_pkg::OPERAND_W-1:0] p
);
  import mul16_pkg::*;

  // pp[i][j] carries weight i+j
  logic [HALF_W-1:0] pp [HALF_W];

  // s[i][j] has weight i+j and c[i][j] has weight i+j+1
  logic [HALF_W-1:0] s [1:HALF_W-1];
  logic [HALF_W-2:0] c [1:HALF_W-1];

  // Carries of the final ripple row
  logic [HALF_W-2:0] rc;

  genvar i, j;

  for (i = 0; i < HALF_W; i++) begin : g_pp
    assign pp[i] = x & {HALF_W{y[i]}};
  end

  // First row only has two inputs per column
  for (j = 0; j < HALF_W-1; j++) begin : g_ha_row
    assign s[1][j] = pp[0][j+1] ^ pp[1][j];
    assign c[1][j] = pp[0][j+1] & pp[1][j];
  end
  assign s[1][HALF_W-1] = pp[1][HALF_W-1];

  // Carry-save rows pass carries down without rippling sideways
  for (i = 2; i < HALF_W; i++) begin : g_fa_row
    for (j = 0; j < HALF_W-1; j++) begin : g_fa
      assign s[i][j] = s[i-1][j+1] ^ pp[i][j] ^ c[i-1][j];
      assign c[i][j] = (s[i-1][j+1] & pp[i][j]) |
                       (c[i-1][j] & (s[i-1][j+1] ^ pp[i][j]));
    end
    // Leftmost column has nothing above it to add
    assign s[i][HALF_W-1] = pp[i][HALF_W-1];
  end

  // Low half of the product falls out of the rows directly
  assign p[0] = pp[0][0];
  for (i = 1; i < HALF_W; i++) begin : g_low
    assign p[i] = s[i][0];
  end

  // Ripple row resolves the last sums and carries into the high half
  assign p[HALF_W] = s[HALF_W-1][1] ^ c[HALF_W-1][0];
  assign rc[0]     = s[HALF_W-1][1] & c[HALF_W-1][0];

  for (j = 1; j < HALF_W-1; j++) begin : g_ripple
    assign p[HALF_W+j] = s[HALF_W-1][j+1] ^ c[HALF_W-1][j] ^ rc[j-1];
    assign rc[j]       = (s[HALF_W-1][j+1] & c[HALF_W-1][j]) |
                         (rc[j-1] & (s[HALF_W-1][j+1] ^ c[HALF_W-1][j]));
  end

  assign p[OPERAND_W-1] = rc[HALF_W-2];

endmodule

//--- hdl/partial_product_stage.sv
`timescale 1ns/100ps

module partial_product_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  mul16_pkg::operand_u             a,
  input  mul16_pkg::operand_u             b,
  output logic [mul16_pkg::OPERAND_W-1:0] pp_ll,
  output logic [mul16_pkg::OPERAND_W-1:0] pp_lh,
  output logic [mul16_pkg::OPERAND_W-1:0] pp_hl,
  output logic [mul16_pkg::OPERAND_W-1:0] pp_hh
);
  import mul16_pkg::*;

  logic [OPERAND_W-1:0] ll;
  logic [OPERAND_W-1:0] lh;
  logic [OPERAND_W-1:0] hl;
  logic [OPERAND_W-1:0] hh;

  // Quadrant products
  array_mult8 mult_ll_i (
    .x (a.halves.lo),
    .y (b.halves.lo),
    .p (ll)
  );

  array_mult8 mult_lh_i (
    .x (a.halves.lo),
    .y (b.halves.hi),
    .p (lh)
  );

  array_mult8 mult_hl_i (
    .x (a.halves.hi),
    .y (b.halves.lo),
    .p (hl)
  );

  array_mult8 mult_hh_i (
    .x (a.halves.hi),
    .y (b.halves.hi),
    .p (hh)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      pp_ll <= '0;
      pp_lh <= '0;
      pp_hl <= '0;
      pp_hh <= '0;
    end else begin
      pp_ll <= ll;
      pp_lh <= lh;
      pp_hl <= hl;
      pp_hh <= hh;
    end
  end

endmodule

//--- hdl/cla_group.sv
`timescale 1ns/100ps

module cla_group #(
  parameter int GROUP_W = 4
) (
  input  logic [GROUP_W-1:0] p,
  input  logic [GROUP_W-1:0] g,
  input  logic               cin,
  output logic [GROUP_W-1:0] sum
);

  // gen[k] is the carry source entering bit k, cin for bit 0
  logic [GROUP_W-1:0] gen;
  logic [GROUP_W-1:0] c;
  logic               term;

  assign gen = {g[GROUP_W-2:0], cin};

  // Each carry as a flat sum of products, no ripple inside the group
  always_comb begin
    for (int i = 0; i < GROUP_W; i++) begin
      c[i] = 1'b0;
      for (int k = 0; k <= i; k++) begin
        term = gen[k];
        for (int m = k; m < i; m++) begin
          term = term & p[m];
        end
        c[i] = c[i] | term;
      end
    end
  end

  assign sum = p ^ c;

endmodule

//--- hdl/cla_adder.sv
`timescale 1ns/100ps

module cla_adder #(
  parameter int GROUP_W = 4
) (
  input  logic [mul16_pkg::PRODUCT_W-1:0] x,
  input  logic [mul16_pkg::PRODUCT_W-1:0] y,
  output logic [mul16_pkg::PRODUCT_W-1:0] sum
);
  import mul16_pkg::*;

  localparam int NUM_GROUPS = PRODUCT_W / GROUP_W;

  logic [PRODUCT_W-1:0]  p;
  logic [PRODUCT_W-1:0]  g;
  // Group propagate counts from group 1 up, group generate stops below the top group
  logic [NUM_GROUPS-1:1] grp_p;
  logic [NUM_GROUPS-2:0] grp_g;
  logic [NUM_GROUPS-1:0] grp_c;
  logic                  term_g;
  logic                  term_c;

  assign p = x ^ y;
  assign g = x & y;

  // Group propagate and generate
  always_comb begin
    for (int n = 1; n < NUM_GROUPS; n++) begin
      grp_p[n] = &p[n*GROUP_W +: GROUP_W];
    end
    for (int n = 0; n < NUM_GROUPS - 1; n++) begin
      grp_g[n] = 1'b0;
      for (int i = 0; i < GROUP_W; i++) begin
        term_g = g[n*GROUP_W+i];
        for (int m = i + 1; m < GROUP_W; m++) begin
          term_g = term_g & p[n*GROUP_W+m];
        end
        grp_g[n] = grp_g[n] | term_g;
      end
    end
  end

  // Second lookahead level across groups with the adder carry-in at zero
  always_comb begin
    grp_c[0] = 1'b0;
    for (int n = 1; n < NUM_GROUPS; n++) begin
      grp_c[n] = 1'b0;
      for (int k = 0; k < n; k++) begin
        term_c = grp_g[k];
        for (int m = k + 1; m < n; m++) begin
          term_c = term_c & grp_p[m];
        end
        grp_c[n] = grp_c[n] | term_c;
      end
    end
  end

  for (genvar n = 0; n < NUM_GROUPS; n++) begin : g_group
    cla_group #(
      .GROUP_W (GROUP_W)
    ) group_i (
      .p   (p[n*GROUP_W +: GROUP_W]),
      .g   (g[n*GROUP_W +: GROUP_W]),
      .cin (grp_c[n]),
      .sum (sum[n*GROUP_W +: GROUP_W])
    );
  end

endmodule

//--- hdl/product_accumulate.sv
`timescale 1ns/100ps

module product_accumulate #(
  parameter int GROUP_W = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [mul16_pkg::OPERAND_W-1:0] pp_ll,
  input  logic [mul16_pkg::OPERAND_W-1:0] pp_lh,
  input  logic [mul16_pkg::OPERAND_W-1:0] pp_hl,
  input  logic [mul16_pkg::OPERAND_W-1:0] pp_hh,
  output logic [mul16_pkg::PRODUCT_W-1:0] product
);
  import mul16_pkg::*;

  logic [PRODUCT_W-1:0] hh_ll;
  logic [PRODUCT_W-1:0] lh_aligned;
  logic [PRODUCT_W-1:0] hl_aligned;
  logic [PRODUCT_W-1:0] partial_sum;
  logic [PRODUCT_W-1:0] final_sum;

  // HH and LL do not overlap, so they are simply joined
  assign hh_ll = {pp_hh, pp_ll};

  // Cross products sit one byte up
  assign lh_aligned = {{HALF_W{1'b0}}, pp_lh, {HALF_W{1'b0}}};
  assign hl_aligned = {{HALF_W{1'b0}}, pp_hl, {HALF_W{1'b0}}};

  cla_adder #(
    .GROUP_W (GROUP_W)
  ) add_lh_i (
    .x   (hh_ll),
    .y   (lh_aligned),
    .sum (partial_sum)
  );

  cla_adder #(
    .GROUP_W (GROUP_W)
  ) add_hl_i (
    .x   (partial_sum),
    .y   (hl_aligned),
    .sum (final_sum)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      product <= '0;
    end else begin
      product <= final_sum;
    end
  end

endmodule

//--- hdl/mul16_pipe.sv
`timescale 1ns/100ps

module mul16_pipe #(
  parameter int GROUP_W = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  mul16_pkg::operand_u             a,
  input  mul16_pkg::operand_u             b,
  output logic [mul16_pkg::PRODUCT_W-1:0] product
);
  import mul16_pkg::*;

  // Registered quadrant products between the two stages
  logic [OPERAND_W-1:0] pp_ll;
  logic [OPERAND_W-1:0] pp_lh;
  logic [OPERAND_W-1:0] pp_hl;
  logic [OPERAND_W-1:0] pp_hh;

  partial_product_stage pp_stage_i (
    .clk   (clk),
    .rst   (rst),
    .a     (a),
    .b     (b),
    .pp_ll (pp_ll),
    .pp_lh (pp_lh),
    .pp_hl (pp_hl),
    .pp_hh (pp_hh)
  );

  product_accumulate #(
    .GROUP_W (GROUP_W)
  ) accum_i (
    .clk     (clk),
    .rst     (rst),
    .pp_ll   (pp_ll),
    .pp_lh   (pp_lh),
    .pp_hl   (pp_hl),
    .pp_hh   (pp_hh),
    .product (product)
  );

endmodule

//--- verif/mul16_pipe_properties.sv
`timescale 1ns/100ps

module mul16_pipe_properties (
  input logic                            clk,
  input logic                            rst,
  input mul16_pkg::operand_u             a,
  input mul16_pkg::operand_u             b,
  input logic [mul16_pkg::PRODUCT_W-1:0] product
);
  import mul16_pkg::*;

  int unsigned assert_failures = 0;

  // Reset clears the product register on the same edge
  assert property (@(posedge clk) rst |=> product == '0)
    else begin
      $error("product not zero after an edge with rst high");
      assert_failures = assert_failures + 1;
    end

  assert property (@(posedge clk) disable iff (rst) !$isunknown(product))
    else begin
      $error("product has unknown bits outside reset");
      assert_failures = assert_failures + 1;
    end

  // Two clean edges mean the product register holds a real result
  assert property (@(posedge clk)
    !$past(rst, 1) && !$past(rst, 2) |->
      product == PRODUCT_W'($past(a.word, 2)) * PRODUCT_W'($past(b.word, 2)))
    else begin
      $error("product does not match operands sampled two edges earlier");
      assert_failures = assert_failures + 1;
    end

endmodule

bind mul16_pipe mul16_pipe_properties props_i (
  .clk     (clk),
  .rst     (rst),
  .a       (a),
  .b       (b),
  .product (product)
);

//--- verif/mul16_pipe_tb.sv
`timescale 1ns/100ps

module mul16_pipe_tb;
  import mul16_pkg::*;

  localparam int RESET_CYCLES   = 10;
  localparam int CORNER_VECS    = 36;
  localparam int CROSS_VECS     = 6;
  localparam int RANDOM_VECS    = 2000;
  localparam int MID_RESET      = 1;
  localparam int DRAIN_CYCLES   = 2;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + CORNER_VECS + CROSS_VECS + RANDOM_VECS +
                                  MID_RESET + DRAIN_CYCLES + 20;

  logic                 clk = 1'b0;
  logic                 rst;
  operand_u             a;
  operand_u             b;
  logic [PRODUCT_W-1:0] product;

  // Expected products in flight with [1] due on product
  logic [PRODUCT_W-1:0] expected_q [2];
  logic [31:0]          rng_state;
  int                   cycle_count = 0;

  logic [OPERAND_W-1:0] corner_vals [6] = '{16'h0000, 16'h0001, 16'h00ff,
                                            16'hff00, 16'hffff, 16'h8000};
  logic [OPERAND_W-1:0] cross_a [CROSS_VECS] = '{16'h00ff, 16'hff80, 16'h80ff,
                                                 16'hffff, 16'hff01, 16'h7fff};
  logic [OPERAND_W-1:0] cross_b [CROSS_VECS] = '{16'hff00, 16'h80ff, 16'hff80,
                                                 16'h00ff, 16'h01ff, 16'hffff};

  mul16_pipe #(
    .GROUP_W (4)
  ) mul16_pipe_i (
    .clk     (clk),
    .rst     (rst),
    .a       (a),
    .b       (b),
    .product (product)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [PRODUCT_W-1:0] exact_product(input logic [OPERAND_W-1:0] x,
                                                         input logic [OPERAND_W-1:0] y);
    logic [PRODUCT_W-1:0] wide_x;
    logic [PRODUCT_W-1:0] wide_y;
    wide_x = x;
    wide_y = y;
    return wide_x * wide_y;
  endfunction

  task automatic check_product(input string name, input logic [PRODUCT_W-1:0] expected,
                               input logic [PRODUCT_W-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "product mismatch");
    end
  endtask

  // Each clock updates the model with the sampled pair, drives the next pair and checks
  task automatic apply_vector(input logic [OPERAND_W-1:0] av, input logic [OPERAND_W-1:0] bv,
                              input logic rv, input string name);
    @(posedge clk);
    if (rst) begin
      expected_q[1] = '0;
      expected_q[0] = '0;
    end else begin
      expected_q[1] = expected_q[0];
      expected_q[0] = exact_product(a.word, b.word);
    end
    a.word <= av;
    b.word <= bv;
    rst    <= rv;
    @(negedge clk);
    check_product(name, expected_q[1], product);
  endtask

  initial begin
    logic [OPERAND_W-1:0] av;
    logic [OPERAND_W-1:0] bv;
    rst           = 1'b1;
    a             = '0;
    b             = '0;
    expected_q[0] = '0;
    expected_q[1] = '0;
    rng_state     = 32'hcf188f73;

    repeat (RESET_CYCLES - 1) apply_vector('0, '0, 1'b1, "reset");

    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 6; j++) begin
        apply_vector(corner_vals[i], corner_vals[j], 1'b0, "corner");
      end
    end

    for (int i = 0; i < CROSS_VECS; i++) begin
      apply_vector(cross_a[i], cross_b[i], 1'b0, "cross_carry");
    end

    for (int i = 0; i < RANDOM_VECS; i++) begin
      rng_state = lcg_next(rng_state);
      av        = rng_state[31:16];
      rng_state = lcg_next(rng_state);
      bv        = rng_state[31:16];
      // Single reset pulse in the middle of the stream
      if (i == RANDOM_VECS / 2) begin
        apply_vector(av, bv, 1'b1, "mid_reset");
      end
      apply_vector(av, bv, 1'b0, "random");
    end

    repeat (DRAIN_CYCLES + 1) apply_vector('0, '0, 1'b0, "drain");

    if (mul16_pipe_i.props_i.assert_failures != 0) begin
      $display("Bound assertions failed %0d times", mul16_pipe_i.props_i.assert_failures);
      $display("*** FAILED ***");
      $fatal(1, "assertion failures");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- mul16_cla.f
hdl/mul16_pkg.sv
hdl/array_mult8.sv
hdl/partial_product_stage.sv
hdl/cla_group.sv
hdl/cla_adder.sv
hdl/product_accumulate.sv
hdl/mul16_pipe.sv
verif/mul16_pipe_properties.sv
verif/mul16_pipe_tb.sv
